//--- Makefile
SRCS := $(wildcard *.sv)

obj_dir/Vaccel_tb: $(SRCS) list.f
	verilator --binary --timing --assert -Wno-fatal --top-module accel_tb -Mdir obj_dir -f list.f

.PHONY: run clean

run: obj_dir/Vaccel_tb
	@out="$$(./obj_dir/Vaccel_tb)"; echo "$$out"; echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf obj_dir

//--- accel_chk.sv
module accel_chk #(
  parameter int credit_depth = 4,
  parameter int blocks = 2
) (
  input logic                               clk,
  input logic                               arst_n,
  input logic                               io_en,
  input logic                               io_wen,
  input logic                               io_rd_valid,
  input logic                               line_valid,
  input logic [$clog2(credit_depth+1)-1:0]  line_count,
  input logic                               hit_valid,
  input logic [$clog2(credit_depth+1)-1:0]  res_count,
  input logic [$clog2(credit_depth+1)-1:0]  scan_credits,
  input logic [blocks-1:0]                  acc_en_b2
);
  timeunit 1ns;
  timeprecision 1ps;

  int assert_fails = 0;

  line_push_room: assert property (@(posedge clk) disable iff (!arst_n)
    line_valid |-> line_count < credit_depth)
    else begin
      assert_fails++;
      $error("line FIFO pushed while full");
    end

  result_push_room: assert property (@(posedge clk) disable iff (!arst_n)
    hit_valid |-> res_count < credit_depth)
    else begin
      assert_fails++;
      $error("result FIFO pushed while full");
    end

  // an underflow of the credit counter would wrap above credit_depth
  credit_range: assert property (@(posedge clk) disable iff (!arst_n)
    scan_credits <= credit_depth)
    else begin
      assert_fails++;
      $error("scan credit count out of range");
    end

  rd_valid_follows_read: assert property (@(posedge clk) disable iff (!arst_n)
    io_en && !io_wen |=> io_rd_valid)
    else begin
      assert_fails++;
      $error("io_rd_valid missing one cycle after a read");
    end

  rd_valid_only_after_read: assert property (@(posedge clk) disable iff (!arst_n)
    io_rd_valid |-> $past(io_en && !io_wen))
    else begin
      assert_fails++;
      $error("io_rd_valid without a read one cycle before");
    end

  b2_idle: assert property (@(posedge clk) disable iff (!arst_n)
    acc_en_b2 == '0)
    else begin
      assert_fails++;
      $error("port b2 enabled");
    end

endmodule

bind accel_wrap accel_chk #(
  .credit_depth(credit_depth),
  .blocks      (blocks)
) chk (
  .clk         (clk),
  .arst_n      (arst_n),
  .io_en       (io_en),
  .io_wen      (io_wen),
  .io_rd_valid (io_rd_valid),
  .line_valid  (line_valid),
  .line_count  (match.line_count),
  .hit_valid   (hit_valid),
  .res_count   (regs.res_count),
  .scan_credits(scan.credits),
  .acc_en_b2   (acc_en_b2)
);

//--- accel_fifo.sv
module accel_fifo #(
  parameter type item_t = logic [7:0],
  parameter int depth = 4
) (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         push,
  input  item_t                        push_item,
  input  logic                         pop,
  output item_t                        pop_item,
  output logic                         not_empty,
  output logic [$clog2(depth+1)-1:0]   count
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int count_w = $clog2(depth + 1);

  item_t mem [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;

  // head of the queue is visible without a pop
  assign pop_item = mem[rd_ptr];
  assign not_empty = (count != '0);

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_item;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop && not_empty) begin
        rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + count_w'(push) - count_w'(pop && not_empty);
    end
  end

endmodule

//--- accel_match.sv
module accel_match #(
  parameter int credit_depth = accel_pkg::credit_depth
) (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          rom_wr_addr,
  input  logic [accel_pkg::line_w-1:0]  rom_wr_data,
  input  logic                          rom_wr_en,
  input  logic                          line_valid,
  input  accel_pkg::line_item_t         line,
  output logic                          credit_return,
  output logic                          hit_valid,
  output accel_pkg::hit_t               hit,
  input  logic                          hit_credit
);

  localparam int word_w = accel_pkg::word_w;
  localparam int mask_w = 2 * accel_pkg::words_per_line;
  localparam int sel_w = $clog2(mask_w);
  localparam int credit_w = $clog2(credit_depth + 1);

  logic [word_w-1:0] pattern [2];
  accel_pkg::line_item_t head;
  logic head_valid;
  logic [credit_w-1:0] line_count;
  logic [mask_w-1:0] head_mask;
  logic [mask_w-1:0] done;
  logic [mask_w-1:0] rem;
  logic [mask_w-1:0] onehot;
  logic [sel_w-1:0] sel_idx;
  logic [credit_w-1:0] res_credits;
  logic emit;
  logic pop;

  always_ff @(posedge clk) begin
    if (rom_wr_en) begin
      pattern[rom_wr_addr] <= rom_wr_data[word_w-1:0];
    end
  end

  accel_fifo #(
    .item_t(accel_pkg::line_item_t),
    .depth (credit_depth)
  ) line_fifo (
    .clk      (clk),
    .arst_n   (arst_n),
    .push     (line_valid),
    .push_item(line),
    .pop      (pop),
    .pop_item (head),
    .not_empty(head_valid),
    .count    (line_count)
  );

  ////////////////////
  // compare and serialize
  ////////////////////

  // bit 2*lane+pat, so the lowest set bit gives lane order then pattern order
  always_comb begin
    head_mask = '0;
    for (int k = 0; k < accel_pkg::words_per_line; k++) begin
      for (int p = 0; p < 2; p++) begin
        if (head_valid && head.data[k*word_w +: word_w] == pattern[p]) begin
          head_mask[2*k+p] = 1'b1;
        end
      end
    end
  end

  assign rem = head_mask & ~done;
  assign onehot = rem & (~rem + 1'b1);
  assign emit = (rem != '0) && (res_credits != '0);

  always_comb begin
    sel_idx = '0;
    for (int i = mask_w - 1; i >= 0; i--) begin
      if (rem[i]) begin
        sel_idx = sel_w'(i);
      end
    end
  end

  // the line leaves the buffer with its last hit, or at once when it has none
  assign pop = head_valid && ((rem & ~(emit ? onehot : '0)) == '0);
  assign credit_return = pop;

  always_ff @(posedge clk) begin
    hit.line_idx <= head.line_idx;
    hit.pat <= sel_idx[0];
    hit.lane <= sel_idx[sel_w-1:1];
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      done <= '0;
      hit_valid <= 1'b0;
      res_credits <= credit_w'(credit_depth);
    end else begin
      done <= pop ? '0 : (done | (emit ? onehot : '0));
      hit_valid <= emit;
      res_credits <= res_credits - credit_w'(emit) + credit_w'(hit_credit);
    end
  end

endmodule

//--- accel_pkg.sv
package accel_pkg;

  ////////////////////
  // widths
  ////////////////////

  localparam int word_w = 32;
  localparam int line_w = 128;
  localparam int words_per_line = line_w / word_w;
  localparam int lane_w = $clog2(words_per_line);
  localparam int line_addr_w = 12;
  localparam int lines = 2 ** line_addr_w;
  localparam int blocks = 2;
  localparam int block_w = $clog2(blocks);
  localparam int credit_depth = 4;
  localparam int io_addr_w = 22;
  localparam int io_strb_w = word_w / 8;

  ////////////////////
  // register byte offsets
  ////////////////////

  localparam logic [7:0] reg_ctrl = 8'h00;
  localparam logic [7:0] reg_status = 8'h04;
  localparam logic [7:0] reg_start = 8'h08;
  localparam logic [7:0] reg_len = 8'h0C;
  localparam logic [7:0] reg_block = 8'h10;
  localparam logic [7:0] reg_result = 8'h14;

  // last is set when the range holds a single line
  typedef struct packed {
    logic [line_addr_w-1:0] start;
    logic [line_addr_w:0] len;
    logic [block_w-1:0] block;
    logic last;
  } scan_cmd_t;

  typedef struct packed {
    logic [line_w-1:0] data;
    logic [line_addr_w-1:0] line_idx;
    logic last;
  } line_item_t;

  typedef struct packed {
    logic [line_addr_w-1:0] line_idx;
    logic pat;
    logic [lane_w-1:0] lane;
  } hit_t;

endpackage

//--- accel_regs.sv
module accel_regs #(
  parameter int io_addr_w = accel_pkg::io_addr_w,
  parameter int credit_depth = accel_pkg::credit_depth
) (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic                            io_en,
  input  logic                            io_wen,
  input  logic [accel_pkg::io_strb_w-1:0] io_strb,
  input  logic [io_addr_w-1:0]            io_addr,
  input  logic [accel_pkg::word_w-1:0]    io_wr_data,
  output logic [accel_pkg::word_w-1:0]    io_rd_data,
  output logic                            io_rd_valid,
  output accel_pkg::scan_cmd_t            cmd,
  output logic                            start,
  input  logic                            busy,
  input  logic                            hit_valid,
  input  accel_pkg::hit_t                 hit,
  output logic                            hit_credit,
  output logic                            error,
  input  logic                            error_ack
);

  localparam int word_w = accel_pkg::word_w;
  localparam int line_addr_w = accel_pkg::line_addr_w;

  logic [word_w-1:0] start_q;
  logic [word_w-1:0] len_q;
  logic [word_w-1:0] block_q;
  logic [7:0] offs;
  logic wr;
  logic rd;
  logic go;
  logic range_bad;
  logic [word_w:0] range_end;
  logic [word_w-1:0] rd_value;
  accel_pkg::hit_t res_head;
  logic res_valid;
  logic [$clog2(credit_depth+1)-1:0] res_count;

  function automatic logic [word_w-1:0] merge(input logic [word_w-1:0] old,
                                              input logic [word_w-1:0] data,
                                              input logic [accel_pkg::io_strb_w-1:0] strb);
    logic [word_w-1:0] r;
    r = old;
    for (int b = 0; b < accel_pkg::io_strb_w; b++) begin
      if (strb[b]) begin
        r[8*b +: 8] = data[8*b +: 8];
      end
    end
    return r;
  endfunction

  assign offs = io_addr[7:0];
  assign wr = io_en && io_wen;
  assign rd = io_en && !io_wen;
  assign go = wr && offs == accel_pkg::reg_ctrl && io_strb[0] && io_wr_data[0];

  assign range_end = {1'b0, start_q} + {1'b0, len_q};
  assign range_bad = (range_end > (word_w + 1)'(accel_pkg::lines)) || (len_q == '0);

  assign cmd.start = start_q[line_addr_w-1:0];
  assign cmd.len = len_q[line_addr_w:0];
  assign cmd.block = block_q[accel_pkg::block_w-1:0];
  assign cmd.last = (len_q == word_w'(1));

  // each result read pops the queue and hands the matcher one credit back
  assign hit_credit = rd && offs == accel_pkg::reg_result && res_valid;

  accel_fifo #(
    .item_t(accel_pkg::hit_t),
    .depth (credit_depth)
  ) result_fifo (
    .clk      (clk),
    .arst_n   (arst_n),
    .push     (hit_valid),
    .push_item(hit),
    .pop      (hit_credit),
    .pop_item (res_head),
    .not_empty(res_valid),
    .count    (res_count)
  );

  always_comb begin
    rd_value = '0;
    case (offs)
      accel_pkg::reg_status: begin
        rd_value[0] = busy || start;
        rd_value[1] = error;
        rd_value[15:8] = 8'(res_count);
      end
      accel_pkg::reg_start: rd_value = start_q;
      accel_pkg::reg_len: rd_value = len_q;
      accel_pkg::reg_block: rd_value = block_q;
      accel_pkg::reg_result: begin
        if (res_valid) begin
          rd_value[31] = 1'b1;
          rd_value[16] = res_head.pat;
          rd_value[13:12] = res_head.lane;
          rd_value[11:0] = res_head.line_idx;
        end
      end
      default: rd_value = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    io_rd_data <= rd_value;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      start_q <= '0;
      len_q <= '0;
      block_q <= '0;
      start <= 1'b0;
      error <= 1'b0;
      io_rd_valid <= 1'b0;
    end else begin
      io_rd_valid <= rd;
      if (wr && offs == accel_pkg::reg_start) start_q <= merge(start_q, io_wr_data, io_strb);
      if (wr && offs == accel_pkg::reg_len) len_q <= merge(len_q, io_wr_data, io_strb);
      if (wr && offs == accel_pkg::reg_block) block_q <= merge(block_q, io_wr_data, io_strb);
      start <= go && !range_bad;
      // a bad range wins over an acknowledge in the same cycle
      if (go && range_bad) begin
        error <= 1'b1;
      end else if (error_ack) begin
        error <= 1'b0;
      end
    end
  end

endmodule

//--- accel_scan.sv
module accel_scan #(
  parameter int blocks = accel_pkg::blocks,
  parameter int line_addr_w = accel_pkg::line_addr_w,
  parameter int credit_depth = accel_pkg::credit_depth
) (
  input  logic                                clk,
  input  logic                                arst_n,
  input  accel_pkg::scan_cmd_t                cmd,
  input  logic                                start,
  output logic                                busy,
  output logic [blocks-1:0]                   mem_en,
  output logic [line_addr_w-1:0]              mem_addr,
  input  logic [blocks*accel_pkg::line_w-1:0] mem_rd_data,
  output logic                                line_valid,
  output accel_pkg::line_item_t               line,
  input  logic                                credit_return
);

  localparam int credit_w = $clog2(credit_depth + 1);
  localparam int line_w = accel_pkg::line_w;

  logic [line_addr_w-1:0] cur;
  logic [line_addr_w:0] remaining;
  logic [accel_pkg::block_w-1:0] blk;
  logic at_last;
  logic [credit_w-1:0] credits;
  logic issue;
  logic rd_pend;
  logic rd_last;
  logic [line_addr_w-1:0] rd_idx;

  // one read per cycle as long as lines remain and the matcher has room
  assign issue = busy && (remaining != '0) && (credits != '0);
  assign mem_addr = cur;

  always_comb begin
    mem_en = '0;
    if (issue) begin
      mem_en[blk] = 1'b1;
    end
  end

  // memory answers one cycle after the enable
  assign line_valid = rd_pend;
  assign line.data = mem_rd_data[blk*line_w +: line_w];
  assign line.line_idx = rd_idx;
  assign line.last = rd_last;

  always_ff @(posedge clk) begin
    if (issue) begin
      rd_idx <= cur;
      rd_last <= at_last;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy <= 1'b0;
      cur <= '0;
      remaining <= '0;
      blk <= '0;
      at_last <= 1'b0;
      credits <= credit_w'(credit_depth);
      rd_pend <= 1'b0;
    end else begin
      credits <= credits - credit_w'(issue) + credit_w'(credit_return);
      rd_pend <= issue;
      if (!busy) begin
        if (start) begin
          busy <= 1'b1;
          cur <= cmd.start;
          remaining <= cmd.len;
          blk <= cmd.block;
          at_last <= cmd.last;
        end
      end else begin
        if (issue) begin
          cur <= cur + 1'b1;
          remaining <= remaining - 1'b1;
          at_last <= (remaining == (line_addr_w + 1)'(2));
        end
        // done once every line went out and the matcher handed all credits back
        if (remaining == '0 && !rd_pend && credits == credit_w'(credit_depth)) begin
          busy <= 1'b0;
        end
      end
    end
  end

endmodule

//--- accel_tb.sv
module accel_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int line_w = accel_pkg::line_w;
  localparam int word_w = accel_pkg::word_w;
  localparam int blocks = accel_pkg::blocks;
  localparam int addr_w = accel_pkg::line_addr_w;
  localparam int io_addr_w = accel_pkg::io_addr_w;
  // the five tests take well under a thousand cycles, the rest is margin for stalls
  localparam int max_cycles = 20000;

  logic clk;
  logic arst_n;
  logic io_en;
  logic io_wen;
  logic [accel_pkg::io_strb_w-1:0] io_strb;
  logic [io_addr_w-1:0] io_addr;
  logic [word_w-1:0] io_wr_data;
  logic [word_w-1:0] io_rd_data;
  logic io_rd_valid;
  logic acc_rom_wr_addr;
  logic [line_w-1:0] acc_rom_wr_data;
  logic acc_rom_wr_en;
  logic [blocks-1:0] acc_en_b1;
  logic [blocks*line_w/8-1:0] acc_wen_b1;
  logic [blocks*addr_w-1:0] acc_addr_b1;
  logic [blocks*line_w-1:0] acc_wr_data_b1;
  logic [blocks*line_w-1:0] acc_rd_data_b1 = '0;
  logic [blocks-1:0] acc_en_b2;
  logic [blocks*line_w/8-1:0] acc_wen_b2;
  logic [blocks*addr_w-1:0] acc_addr_b2;
  logic [blocks*line_w-1:0] acc_wr_data_b2;
  logic [blocks*line_w-1:0] acc_rd_data_b2 = '0;
  logic error;
  logic error_ack;

  logic [line_w-1:0] mem [blocks][accel_pkg::lines];
  logic [word_w-1:0] pattern [2];
  logic [word_w-1:0] exp_q[$];
  logic [word_w-1:0] got_q[$];
  int seed;
  int errors;
  int checks;
  int cycles = 0;

  accel_wrap #(
    .credit_depth(accel_pkg::credit_depth)
  ) UUT (
    .clk            (clk),
    .arst_n         (arst_n),
    .io_en          (io_en),
    .io_wen         (io_wen),
    .io_strb        (io_strb),
    .io_addr        (io_addr),
    .io_wr_data     (io_wr_data),
    .io_rd_data     (io_rd_data),
    .io_rd_valid    (io_rd_valid),
    .acc_rom_wr_addr(acc_rom_wr_addr),
    .acc_rom_wr_data(acc_rom_wr_data),
    .acc_rom_wr_en  (acc_rom_wr_en),
    .acc_en_b1      (acc_en_b1),
    .acc_wen_b1     (acc_wen_b1),
    .acc_addr_b1    (acc_addr_b1),
    .acc_wr_data_b1 (acc_wr_data_b1),
    .acc_rd_data_b1 (acc_rd_data_b1),
    .acc_en_b2      (acc_en_b2),
    .acc_wen_b2     (acc_wen_b2),
    .acc_addr_b2    (acc_addr_b2),
    .acc_wr_data_b2 (acc_wr_data_b2),
    .acc_rd_data_b2 (acc_rd_data_b2),
    .error          (error),
    .error_ack      (error_ack)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // accelerator memory answers port b1 one cycle after the enable
  always @(posedge clk) begin
    for (int b = 0; b < blocks; b++) begin
      if (acc_en_b1[b]) begin
        acc_rd_data_b1[b*line_w +: line_w] <= mem[b][acc_addr_b1[b*addr_w +: addr_w]];
      end
    end
  end

  // scanning only reads through b1, so no write may appear and b2 stays idle
  always @(negedge clk) begin
    if (arst_n && {acc_wen_b1, acc_wr_data_b1} !== '0) begin
      $display("FAIL b1 write port: expected 0, actual %h", {acc_wen_b1, acc_wr_data_b1});
      errors++;
    end
    if (arst_n && {acc_en_b2, acc_wen_b2, acc_addr_b2, acc_wr_data_b2} !== '0) begin
      $display("FAIL b2 port: expected 0, actual %h",
               {acc_en_b2, acc_wen_b2, acc_addr_b2, acc_wr_data_b2});
      errors++;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", max_cycles);
      $display("Simulation FAILED");
      $finish;
    end
  end

  ////////////////////
  // bus and memory tasks
  ////////////////////

  task automatic fill_memory();
    for (int b = 0; b < blocks; b++) begin
      for (int i = 0; i < accel_pkg::lines; i++) begin
        for (int w = 0; w < accel_pkg::words_per_line; w++) begin
          mem[b][i][w*word_w +: word_w] = $random(seed);
        end
      end
    end
  endtask

  task automatic plant(input int blk, input int line_idx, input int lane, input logic [31:0] w);
    mem[blk][line_idx][lane*word_w +: word_w] = w;
  endtask

  task automatic load_rom(input int p, input logic [31:0] value);
    acc_rom_wr_en = 1'b1;
    acc_rom_wr_addr = p[0];
    acc_rom_wr_data = {$random(seed), $random(seed), $random(seed), value};
    @(negedge clk);
    acc_rom_wr_en = 1'b0;
    pattern[p] = value;
  endtask

  task automatic io_write(input logic [7:0] offs, input logic [31:0] data,
                          input logic [3:0] strb);
    io_en = 1'b1;
    io_wen = 1'b1;
    io_addr = io_addr_w'(offs);
    io_wr_data = data;
    io_strb = strb;
    @(negedge clk);
    io_en = 1'b0;
    io_wen = 1'b0;
  endtask

  task automatic io_read(input logic [7:0] offs, output logic [31:0] data);
    io_en = 1'b1;
    io_wen = 1'b0;
    io_addr = io_addr_w'(offs);
    @(negedge clk);
    io_en = 1'b0;
    while (!io_rd_valid) @(negedge clk);
    data = io_rd_data;
  endtask

  task automatic read_expect(input string name, input logic [7:0] offs,
                             input logic [31:0] exp);
    logic [31:0] data;
    io_read(offs, data);
    checks++;
    if (data !== exp) begin
      $display("FAIL %s: expected %h, actual %h", name, exp, data);
      errors++;
    end
  endtask

  ////////////////////
  // reference and compare
  ////////////////////

  // hits in lane order, pattern 0 before pattern 1 inside a lane
  function automatic void expected_hits(input int blk, input int first, input int len);
    logic [11:0] idx;
    exp_q.delete();
    for (int l = first; l < first + len; l++) begin
      idx = l[11:0];
      for (int k = 0; k < accel_pkg::words_per_line; k++) begin
        for (int p = 0; p < 2; p++) begin
          if (mem[blk][l][k*word_w +: word_w] == pattern[p]) begin
            exp_q.push_back({1'b1, 14'b0, p[0], 2'b0, k[1:0], idx});
          end
        end
      end
    end
  endfunction

  task automatic compare_results(input string name);
    checks++;
    if (got_q.size() != exp_q.size()) begin
      $display("FAIL %s result count: expected %0d, actual %0d", name, exp_q.size(),
               got_q.size());
      errors++;
    end
    for (int i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
      checks++;
      if (got_q[i] !== exp_q[i]) begin
        $display("FAIL %s result %0d: expected %h, actual %h", name, i, exp_q[i], got_q[i]);
        errors++;
      end
    end
    read_expect({name, " empty queue"}, accel_pkg::reg_result, 32'h0);
  endtask

  // results are popped while the scan runs, gap idle cycles before each pop
  task automatic run_scan(input string name, input int blk, input int first, input int len,
                          input int gap);
    logic [31:0] data;
    logic done;
    expected_hits(blk, first, len);
    got_q.delete();
    io_write(accel_pkg::reg_start, first, 4'hf);
    io_write(accel_pkg::reg_len, len, 4'hf);
    io_write(accel_pkg::reg_block, blk, 4'hf);
    io_write(accel_pkg::reg_ctrl, 32'h1, 4'hf);
    done = 1'b0;
    while (!done) begin
      repeat (gap) @(negedge clk);
      io_read(accel_pkg::reg_result, data);
      if (data[31]) begin
        got_q.push_back(data);
      end else begin
        io_read(accel_pkg::reg_status, data);
        done = !data[0] && data[15:8] == 8'h0;
      end
    end
    compare_results(name);
  endtask

  initial begin
    seed = 32'he9e3;
    errors = 0;
    checks = 0;
    arst_n = 1'b0;
    io_en = 1'b0;
    io_wen = 1'b0;
    io_strb = '0;
    io_addr = '0;
    io_wr_data = '0;
    acc_rom_wr_addr = 1'b0;
    acc_rom_wr_data = '0;
    acc_rom_wr_en = 1'b0;
    error_ack = 1'b0;
    fill_memory();
    repeat (3) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);

    read_expect("reset status", accel_pkg::reg_status, 32'h0);
    read_expect("reset start", accel_pkg::reg_start, 32'h0);
    read_expect("reset len", accel_pkg::reg_len, 32'h0);
    read_expect("reset block", accel_pkg::reg_block, 32'h0);
    io_write(accel_pkg::reg_start, 32'h0000_0123, 4'hf);
    io_write(accel_pkg::reg_len, 32'h0000_0010, 4'hf);
    io_write(accel_pkg::reg_block, 32'h0000_0001, 4'hf);
    read_expect("start readback", accel_pkg::reg_start, 32'h0000_0123);
    read_expect("len readback", accel_pkg::reg_len, 32'h0000_0010);
    read_expect("block readback", accel_pkg::reg_block, 32'h0000_0001);
    io_write(accel_pkg::reg_len, 32'haabb_ccdd, 4'b0101);
    read_expect("len byte strobes", accel_pkg::reg_len, 32'h00bb_00dd);
    io_write(accel_pkg::reg_start, 32'h1122_3344, 4'b1010);
    read_expect("start byte strobes", accel_pkg::reg_start, 32'h1100_3323);

    load_rom(0, 32'hcafe_0001);
    load_rom(1, 32'h5eed_0002);
    plant(0, 102, 0, pattern[0]);
    plant(0, 105, 2, pattern[1]);
    plant(0, 109, 1, pattern[1]);
    plant(0, 109, 3, pattern[0]);
    plant(0, 115, 1, pattern[0]);
    run_scan("block 0 scan", 0, 100, 16, 0);

    for (int k = 0; k < 4; k++) begin
      plant(1, 2001, k, pattern[0]);
    end
    plant(1, 2003, 0, pattern[0]);
    plant(1, 2003, 1, pattern[1]);
    plant(1, 2003, 3, pattern[1]);
    plant(1, 2007, 2, pattern[0]);
    plant(1, 2007, 3, pattern[1]);
    run_scan("block 1 back-pressure", 1, 2000, 8, 12);

    // the old patterns stay planted in lines 302 and 303
    plant(0, 302, 1, pattern[0]);
    plant(0, 303, 2, pattern[1]);
    load_rom(0, 32'h0bad_f00d);
    load_rom(1, 32'h7777_1234);
    plant(0, 300, 3, pattern[0]);
    plant(0, 301, 0, pattern[1]);
    run_scan("ROM rewrite", 0, 300, 4, 0);

    io_write(accel_pkg::reg_start, 32'd4090, 4'hf);
    io_write(accel_pkg::reg_len, 32'd10, 4'hf);
    io_write(accel_pkg::reg_ctrl, 32'h1, 4'hf);
    read_expect("range error status", accel_pkg::reg_status, 32'h0000_0002);
    read_expect("range error result", accel_pkg::reg_result, 32'h0);
    checks++;
    if (error !== 1'b1) begin
      $display("error output did not rise after a start with a bad range");
      errors++;
    end
    error_ack = 1'b1;
    @(negedge clk);
    error_ack = 1'b0;
    read_expect("error cleared status", accel_pkg::reg_status, 32'h0);
    checks++;
    if (error !== 1'b0) begin
      $display("error output stayed high after error_ack");
      errors++;
    end

    errors += UUT.chk.assert_fails;
    $display("checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
             UUT.chk.assert_fails);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- accel_wrap.sv
module accel_wrap #(
  parameter int io_addr_w = accel_pkg::io_addr_w,
  parameter int blocks = accel_pkg::blocks,
  parameter int line_addr_w = accel_pkg::line_addr_w,
  parameter int credit_depth = accel_pkg::credit_depth
) (
  input  logic                                      clk,
  input  logic                                      arst_n,

  input  logic                                      io_en,
  input  logic                                      io_wen,
  input  logic [accel_pkg::io_strb_w-1:0]           io_strb,
  input  logic [io_addr_w-1:0]                      io_addr,
  input  logic [accel_pkg::word_w-1:0]              io_wr_data,
  output logic [accel_pkg::word_w-1:0]              io_rd_data,
  output logic                                      io_rd_valid,

  input  logic                                      acc_rom_wr_addr,
  input  logic [accel_pkg::line_w-1:0]              acc_rom_wr_data,
  input  logic                                      acc_rom_wr_en,

  output logic [blocks-1:0]                         acc_en_b1,
  output logic [blocks*accel_pkg::line_w/8-1:0]     acc_wen_b1,
  output logic [blocks*line_addr_w-1:0]             acc_addr_b1,
  output logic [blocks*accel_pkg::line_w-1:0]       acc_wr_data_b1,
  input  logic [blocks*accel_pkg::line_w-1:0]       acc_rd_data_b1,

  output logic [blocks-1:0]                         acc_en_b2,
  output logic [blocks*accel_pkg::line_w/8-1:0]     acc_wen_b2,
  output logic [blocks*line_addr_w-1:0]             acc_addr_b2,
  output logic [blocks*accel_pkg::line_w-1:0]       acc_wr_data_b2,
  input  logic [blocks*accel_pkg::line_w-1:0]       acc_rd_data_b2,

  output logic                                      error,
  input  logic                                      error_ack
);

  accel_pkg::scan_cmd_t cmd;
  accel_pkg::line_item_t line;
  accel_pkg::hit_t hit;
  logic start;
  logic busy;
  logic line_valid;
  logic line_credit;
  logic hit_valid;
  logic hit_credit;
  logic [line_addr_w-1:0] mem_addr;

  // scanning only reads, and only through b1
  assign acc_wen_b1 = '0;
  assign acc_wr_data_b1 = '0;
  assign acc_addr_b1 = {blocks{mem_addr}};

  // b2 stays on the port list for the wrapper interface only
  assign acc_en_b2 = '0;
  assign acc_wen_b2 = '0;
  assign acc_addr_b2 = '0;
  assign acc_wr_data_b2 = '0;

  accel_regs #(
    .io_addr_w   (io_addr_w),
    .credit_depth(credit_depth)
  ) regs (
    .clk        (clk),
    .arst_n     (arst_n),
    .io_en      (io_en),
    .io_wen     (io_wen),
    .io_strb    (io_strb),
    .io_addr    (io_addr),
    .io_wr_data (io_wr_data),
    .io_rd_data (io_rd_data),
    .io_rd_valid(io_rd_valid),
    .cmd        (cmd),
    .start      (start),
    .busy       (busy),
    .hit_valid  (hit_valid),
    .hit        (hit),
    .hit_credit (hit_credit),
    .error      (error),
    .error_ack  (error_ack)
  );

  accel_scan #(
    .blocks      (blocks),
    .line_addr_w (line_addr_w),
    .credit_depth(credit_depth)
  ) scan (
    .clk          (clk),
    .arst_n       (arst_n),
    .cmd          (cmd),
    .start        (start),
    .busy         (busy),
    .mem_en       (acc_en_b1),
    .mem_addr     (mem_addr),
    .mem_rd_data  (acc_rd_data_b1),
    .line_valid   (line_valid),
    .line         (line),
    .credit_return(line_credit)
  );

  accel_match #(
    .credit_depth(credit_depth)
  ) match (
    .clk          (clk),
    .arst_n       (arst_n),
    .rom_wr_addr  (acc_rom_wr_addr),
    .rom_wr_data  (acc_rom_wr_data),
    .rom_wr_en    (acc_rom_wr_en),
    .line_valid   (line_valid),
    .line         (line),
    .credit_return(line_credit),
    .hit_valid    (hit_valid),
    .hit          (hit),
    .hit_credit   (hit_credit)
  );

endmodule

//--- list.f
accel_pkg.sv
accel_fifo.sv
accel_scan.sv
accel_match.sv
accel_regs.sv
accel_wrap.sv
accel_chk.sv
accel_tb.sv
